//--- project.f
+incdir+common
common/qBridgePkg.sv
rtl/hostPort/hostRegisters.sv
rtl/qbusSlave/qbusSlave.sv
rtl/statusFlags.sv
rtl/qBridgeTop.sv
verification/qBridgeTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module qBridgeTb -Mdir obj_dir &&
./obj_dir/VqBridgeTb | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- verification/qBridgeTb.sv
`timescale 1ns/1ps
`include "qBridge_config.svh"

module qBridgeTb
    import qBridgePkg::*;
();

    localparam int clkPeriod      = 4;             // ns
    localparam int resetCycles    = 16;
    localparam int transCount     = 400;
    localparam int maxTransCycles = 12;            // Longest Qbus cycle plus slack
    localparam logic [`QADDR_W-1:0]     ipQAddress    = `QADDR_IP;
    localparam logic [`QADDR_W-1:0]     saQAddress    = `QADDR_SA;
    localparam logic [`HOST_ADDR_W-1:0] irHostAddress = `FADDR_IR;
    localparam logic [`HOST_ADDR_W-1:0] saHostAddress = `FADDR_SA;

    logic       BRPLYf;
    logic       F_IP_read_enable;
    hostBusT    host;
    qbusInT     qbusIn;
    hostReadT   hostRead;
    qbusOutT    qbusOut;
    logic       hostIrq;

    // Reference model
    logic [`DATA_W-1:0] mSaStatus;                 // Host written, PDP-11 read
    logic [`DATA_W-1:0] mSaAddress;                // PDP-11 written, host read
    statusFlagsT        mFlags;                    // Sticky event flags
    statusFlagsT        mSnapshot;                 // Copy taken at host address latch

    logic [31:0]        rng;
    int                 errorCount;
    int                 checkCount;

    qBridgeTop u_dut (
        .BRPLYf           (BRPLYf),
        .F_IP_read_enable (F_IP_read_enable),
        .host             (host),
        .qbusIn           (qbusIn),
        .hostRead         (hostRead),
        .qbusOut          (qbusOut),
        .hostIrq          (hostIrq)
    );

    initial
    begin
        BRPLYf = 1'b0;
        forever #(clkPeriod / 2) BRPLYf = ~BRPLYf;
    end

    // Watchdog sized from the transaction count
    initial
    begin
        #((resetCycles + transCount * maxTransCycles) * clkPeriod + 200);
        $display("Watchdog expired before the test sequence completed");
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compareBit(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic compareWord(input string name, input logic [`DATA_W-1:0] expected,
                               input logic [`DATA_W-1:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkBus(input logic expReply, input logic expOe,
                            input logic [`DATA_W-1:0] expDal);
        compareBit("qbusOut.reply", expReply, qbusOut.reply);
        compareBit("qbusOut.dalOe", expOe, qbusOut.dalOe);
        if (expOe)                                 // DAL only meaningful while driven
            compareWord("qbusOut.dal", expDal, qbusOut.dal);
    endtask

    ////////////////////
    // Host bus access
    ////////////////////

    task automatic hostAccess(input logic doRead, input logic [`HOST_ADDR_W-1:0] addr,
                              input logic [1:0] byteEn, input logic [`DATA_W-1:0] data);
        hostRegE            target;
        logic [`DATA_W-1:0] expData;
        if (addr[`HOST_ADDR_W-1:1] == irHostAddress[`HOST_ADDR_W-1:1])
            target = regIr;
        else if (addr[`HOST_ADDR_W-1:1] == saHostAddress[`HOST_ADDR_W-1:1])
            target = regSa;
        else
            target = regNone;
        @(posedge BRPLYf);
        host.addrLatch <= 1'b1;                    // Address phase
        host.addr      <= addr;
        @(posedge BRPLYf);
        mSnapshot = mFlags;                        // Taken at the latch edge
        host.addrLatch <= 1'b0;
        host.chipSel   <= 1'b1;
        host.readEn    <= doRead;
        host.writeEn   <= !doRead;
        host.byteEn    <= byteEn;
        host.data      <= data;
        if (doRead)
        begin
            expData = '0;                          // Unmapped words read zero
            if (target == regIr)
                expData = {{(`DATA_W-$bits(statusFlagsT)){1'b0}}, mSnapshot};
            else if (target == regSa)
                expData = mSaAddress;
            for (int i = 0; i < 2; i++)            // Data must hold over two read cycles
            begin
                @(negedge BRPLYf);
                compareBit("hostRead.oe", 1'b1, hostRead.oe);
                compareWord("hostRead.data", expData, hostRead.data);
                @(posedge BRPLYf);
            end
            if (target == regIr)
                mFlags = '0;                       // Cleared by the read
        end
        else
        begin
            @(posedge BRPLYf);                     // Write edge
            if (target == regSa && byteEn[0])
                mSaStatus[7:0] = data[7:0];
            if (target == regSa && byteEn[1])
                mSaStatus[`DATA_W-1:8] = data[`DATA_W-1:8];
        end
        host.chipSel <= 1'b0;
        host.readEn  <= 1'b0;
        host.writeEn <= 1'b0;
        @(negedge BRPLYf);
        compareBit("hostRead.oe", 1'b0, hostRead.oe);
        compareBit("hostIrq", |mFlags, hostIrq);
    endtask

    ////////////////////
    // Qbus slave cycle
    ////////////////////

    task automatic qbusAccess(input logic doRead, input logic [`QADDR_W-1:0] addr,
                              input logic bs7Val, input logic initVal, input logic wtbtVal,
                              input logic [`DATA_W-1:0] wdata, input int holdCycles);
        logic               isIp;
        logic               isSa;
        logic               hit;
        logic [`DATA_W-1:0] expDal;
        isIp   = addr[`QDEC_MSB:`QDEC_LSB] == ipQAddress[`QDEC_MSB:`QDEC_LSB];
        isSa   = addr[`QDEC_MSB:`QDEC_LSB] == saQAddress[`QDEC_MSB:`QDEC_LSB];
        hit    = bs7Val && !initVal && (isIp || isSa);
        expDal = isSa ? mSaStatus : '0;            // IP reads as zero
        @(posedge BRPLYf);
        qbusIn.sync <= 1'b1;                       // Address phase
        qbusIn.bs7  <= bs7Val;
        qbusIn.wtbt <= wtbtVal;
        qbusIn.dal  <= addr;
        @(negedge BRPLYf);
        checkBus(1'b0, 1'b0, '0);
        @(posedge BRPLYf);
        qbusIn.din  <= doRead;                     // Data phase
        qbusIn.dout <= !doRead;
        qbusIn.init <= initVal;
        qbusIn.dal  <= {{(`QADDR_W-`DATA_W){1'b0}}, wdata};
        @(negedge BRPLYf);
        checkBus(1'b0, 1'b0, '0);                  // Strobe seen but no reply yet
        @(posedge BRPLYf);
        if (hit && doRead && isIp)
            mFlags.ipRead = 1'b1;
        else if (hit && doRead)
            mFlags.saRead = 1'b1;
        else if (hit && isIp)
        begin
            mFlags.ipWritten = 1'b1;
            mSaStatus        = '0;                 // IP write resets the controller
        end
        else if (hit)
        begin
            mFlags.saWritten = 1'b1;
            if (!wtbtVal)
                mSaAddress = wdata;                // Word write
            else if (addr[0])
                mSaAddress[`DATA_W-1:8] = wdata[`DATA_W-1:8];
            else
                mSaAddress[7:0] = wdata[7:0];
        end
        for (int i = 0; i < holdCycles; i++)
        begin
            @(negedge BRPLYf);
            checkBus(hit, hit && doRead, expDal);
            @(posedge BRPLYf);
        end
        qbusIn.din  <= 1'b0;
        qbusIn.dout <= 1'b0;
        @(negedge BRPLYf);
        checkBus(hit, hit && doRead, expDal);      // Reply drops one cycle later
        @(posedge BRPLYf);
        qbusIn <= '0;                              // End of bus cycle
        @(negedge BRPLYf);
        checkBus(1'b0, 1'b0, '0);
        compareBit("hostIrq", |mFlags, hostIrq);
    endtask

    ////////////////////
    // IR read overlapping a Qbus event
    ////////////////////

    // Host latches IR in cycle 1 and reads in cycles 2 and 3
    // The din cycle lands on the latch, on the clear or just after it
    task automatic readIrDuringEvent(input int lead, input logic toIp);
        statusFlagsT        ev;
        int                 evCycle;
        hostBusT            hNext;
        qbusInT             qNext;
        logic               reading;
        logic [`DATA_W-1:0] expDal;
        ev      = '0;
        ev.ipRead = toIp;
        ev.saRead = !toIp;
        evCycle = 1 + lead;                        // Cycle with din high
        expDal  = toIp ? '0 : mSaStatus;
        for (int c = 0; c < 6; c++)
        begin
            @(posedge BRPLYf);
            if (c == 2)
                mSnapshot = mFlags;                // Flags as they were before this edge
            if (c == 3)
                mFlags = (evCycle == 2) ? ev : '0; // Event in the clear cycle survives
            else if (c == evCycle + 1)
                mFlags = statusFlagsT'(mFlags | ev);
            reading         = c == 2 || c == 3;
            hNext           = '0;
            hNext.addrLatch = c == 1;
            hNext.addr      = irHostAddress;
            hNext.chipSel   = reading;
            hNext.readEn    = reading;
            host           <= hNext;
            qNext           = '0;
            qNext.sync      = c >= evCycle - 1 && c <= evCycle + 1;
            qNext.bs7       = qNext.sync;
            qNext.din       = c == evCycle;
            if (c == evCycle - 1)
                qNext.dal = toIp ? ipQAddress : saQAddress;
            qbusIn         <= qNext;
            @(negedge BRPLYf);
            compareBit("hostRead.oe", reading, hostRead.oe);
            if (reading)
                compareWord("hostRead.data",
                            {{(`DATA_W-$bits(statusFlagsT)){1'b0}}, mSnapshot},
                            hostRead.data);
            checkBus(c == evCycle + 1, c == evCycle + 1, expDal);
            compareBit("hostIrq", |mFlags, hostIrq);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        logic [31:0]         ctl;
        logic [`DATA_W-1:0]  value;
        logic [`QADDR_W-1:0] missAddress;
        int                  hold;
        host             <= '0;
        qbusIn           <= '0;
        F_IP_read_enable <= 1'b1;
        mSaStatus  = '0;
        mSaAddress = '0;
        mFlags     = '0;
        mSnapshot  = '0;
        rng        = 32'h8d9f;
        errorCount = 0;
        checkCount = 0;
        repeat (resetCycles) @(posedge BRPLYf);
        F_IP_read_enable <= 1'b0;
        @(negedge BRPLYf);
        checkBus(1'b0, 1'b0, '0);                  // Quiet after reset
        compareBit("hostRead.oe", 1'b0, hostRead.oe);
        compareBit("hostIrq", 1'b0, hostIrq);
        for (int n = 0; n < transCount; n++)
        begin
            rng   = lcgNext(rng);
            ctl   = rng;
            rng   = lcgNext(rng);
            value = rng[31:16];                    // Upper LCG bits
            hold  = 1 + int'(ctl[27:26]);
            missAddress = {value, ctl[5:0]};
            if (missAddress[`QDEC_MSB:`QDEC_LSB] == ipQAddress[`QDEC_MSB:`QDEC_LSB] ||
                missAddress[`QDEC_MSB:`QDEC_LSB] == saQAddress[`QDEC_MSB:`QDEC_LSB])
                missAddress[8:5] = ~missAddress[8:5];
            case (ctl[31:29])
                3'd0: hostAccess(1'b0, {saHostAddress[7:1], ctl[21]}, ctl[25:24], value);
                3'd1: hostAccess(1'b1, saHostAddress, 2'b11, '0);
                3'd2: hostAccess(1'b1, irHostAddress, 2'b11, '0);
                3'd3: hostAccess(ctl[20], ctl[15:8], ctl[25:24], value);     // Whole map
                3'd4: qbusAccess(1'b1, saQAddress, 1'b1, 1'b0, 1'b0, '0, hold);
                3'd5: qbusAccess(1'b0, {saQAddress[`QADDR_W-1:1], ctl[18] & ctl[19]},
                                 1'b1, 1'b0, ctl[19], value, hold);
                3'd6: qbusAccess(ctl[20], ipQAddress, 1'b1, 1'b0, ctl[19], value, hold);
                default:
                begin
                    if (ctl[23:22] == 2'd0)        // Outside the I/O page
                        qbusAccess(ctl[20], saQAddress, 1'b0, 1'b0, 1'b0, value, hold);
                    else if (ctl[23:22] == 2'd1)   // Not our register pair
                        qbusAccess(ctl[20], missAddress, 1'b1, 1'b0, 1'b0, value, hold);
                    else if (ctl[23:22] == 2'd2)   // Bus init during the cycle
                        qbusAccess(ctl[20], ctl[21] ? ipQAddress : saQAddress,
                                   1'b1, 1'b1, 1'b0, value, hold);
                    else                           // PDP-11 read while the host reads IR
                        readIrDuringEvent(int'(ctl[27:26]) % 3, ctl[21]);
                end
            endcase
        end
        repeat (4) @(posedge BRPLYf);
        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- rtl/qBridgeTop.sv
`timescale 1ns/1ps
`include "qBridge_config.svh"

module qBridgeTop
    import qBridgePkg::*;
(
    input  logic        BRPLYf,             // System clock
    input  logic        F_IP_read_enable,   // Async reset, active high
    input  hostBusT     host,               // Host memory bus
    input  qbusInT      qbusIn,             // Qbus, sampled levels
    output hostReadT    hostRead,
    output qbusOutT     qbusOut,
    output logic        hostIrq             // To the host processor
);

    ////////////////////
    // Internal wiring
    ////////////////////

    logic [`DATA_W-1:0] saAddress;          // Qbus -> host
    logic [`DATA_W-1:0] saStatus;           // Host -> Qbus
    statusFlagsT        qEvent;
    statusFlagsT        flagSnapshot;
    logic               ipWriteClear;
    logic               irReadClear;

    // Host side registers
    hostRegisters u_hostRegisters (
        .BRPLYf           (BRPLYf),
        .F_IP_read_enable (F_IP_read_enable),
        .host             (host),
        .saAddress        (saAddress),
        .flagSnapshot     (flagSnapshot),
        .ipWriteClear     (ipWriteClear),
        .hostRead         (hostRead),
        .saStatus         (saStatus),
        .irReadClear      (irReadClear)
    );

    // PDP-11 facing slave
    qbusSlave u_qbusSlave (
        .BRPLYf           (BRPLYf),
        .F_IP_read_enable (F_IP_read_enable),
        .qbusIn           (qbusIn),
        .saStatus         (saStatus),
        .qbusOut          (qbusOut),
        .saAddress        (saAddress),
        .qEvent           (qEvent),
        .ipWriteClear     (ipWriteClear)
    );

    // Event flags and interrupt
    statusFlags u_statusFlags (
        .BRPLYf           (BRPLYf),
        .F_IP_read_enable (F_IP_read_enable),
        .qEvent           (qEvent),
        .addrLatch        (host.addrLatch),
        .irReadClear      (irReadClear),
        .flagSnapshot     (flagSnapshot),
        .hostIrq          (hostIrq)
    );

endmodule

//--- rtl/statusFlags.sv
`timescale 1ns/1ps

module statusFlags
    import qBridgePkg::*;
(
    input  logic        BRPLYf,             // System clock
    input  logic        F_IP_read_enable,   // Async reset, active high
    input  statusFlagsT qEvent,             // Pulses from the Qbus slave
    input  logic        addrLatch,          // Host address phase
    input  logic        irReadClear,        // Host IR read started
    output statusFlagsT flagSnapshot,       // Frozen copy for the host
    output logic        hostIrq
);

    statusFlagsT flags;                     // Live sticky flags

    ////////////////////
    // Sticky flags
    ////////////////////

    // A new event in the clear cycle survives
    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
            flags <= '0;
        else if (irReadClear)
            flags <= qEvent;
        else
            flags <= statusFlagsT'(flags | qEvent);
    end

    // Snapshot on every host address phase, IR read returns this
    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
            flagSnapshot <= '0;
        else if (addrLatch)
            flagSnapshot <= flags;
    end

    assign hostIrq = |flags;                // Any pending PDP-11 access

endmodule

//--- rtl/qbusSlave/qbusSlave.sv
`timescale 1ns/1ps
`include "qBridge_config.svh"

module qbusSlave
    import qBridgePkg::*;
(
    input  logic                BRPLYf,             // System clock
    input  logic                F_IP_read_enable,   // Async reset, active high
    input  qbusInT              qbusIn,             // Sampled Qbus levels
    input  logic [`DATA_W-1:0]  saStatus,           // Host written status word
    output qbusOutT             qbusOut,
    output logic [`DATA_W-1:0]  saAddress,          // PDP-11 written address word
    output statusFlagsT         qEvent,             // One-cycle event pulses
    output logic                ipWriteClear        // PDP-11 wrote IP
);

    localparam logic [`QADDR_W-1:0] ipQAddress = `QADDR_IP;
    localparam logic [`QADDR_W-1:0] saQAddress = `QADDR_SA;

    qSlaveStateE    state;
    qSlaveStateE    stateNext;
    qSelE           sel;                            // Latched at sync rise
    qSelE           selDecoded;                     // Live decode of the DAL
    logic           addr0;                          // Byte select for byte writes
    logic           syncD;                          // Sync one cycle back
    logic           syncRise;
    logic           cycleAbort;                     // Sync gone or init
    logic           readStart;
    logic           writeStart;

    ////////////////////
    // Address decode
    ////////////////////

    assign syncRise   = qbusIn.sync && !syncD;
    assign cycleAbort = !qbusIn.sync || qbusIn.init;

    always_comb
    begin
        selDecoded = selNone;
        if (qbusIn.bs7)                             // I/O page only
        begin
            if (qbusIn.dal[`QDEC_MSB:`QDEC_LSB] == ipQAddress[`QDEC_MSB:`QDEC_LSB])
                selDecoded = selIp;
            else if (qbusIn.dal[`QDEC_MSB:`QDEC_LSB] == saQAddress[`QDEC_MSB:`QDEC_LSB])
                selDecoded = selSa;
        end
    end

    // Data phase starts, din wins if both show up
    assign readStart  = state == qAddressed && !cycleAbort && qbusIn.din;
    assign writeStart = state == qAddressed && !cycleAbort && !qbusIn.din && qbusIn.dout;

    ////////////////////
    // Slave cycle FSM
    ////////////////////

    always_comb
    begin
        stateNext = state;
        if (cycleAbort)
            stateNext = qIdle;
        else
        begin
            case (state)
                qIdle:
                    if (syncRise && selDecoded != selNone)
                        stateNext = qAddressed;
                qAddressed:
                    if (readStart)
                        stateNext = qReadData;
                    else if (writeStart)
                        stateNext = qWriteData;
                qReadData:
                    if (!qbusIn.din)                // Drop reply the cycle after
                        stateNext = qAddressed;
                qWriteData:
                    if (!qbusIn.dout)
                        stateNext = qAddressed;
                default:
                    stateNext = qIdle;
            endcase
        end
    end

    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            state <= qIdle;
            sel   <= selNone;
            addr0 <= 1'b0;
            syncD <= 1'b0;
        end
        else
        begin
            state <= stateNext;
            syncD <= qbusIn.sync;
            if (state == qIdle && syncRise)         // Address phase
            begin
                sel   <= selDecoded;
                addr0 <= qbusIn.dal[0];
            end
        end
    end

    ////////////////////
    // SA address register
    ////////////////////

    // Word write unless wtbt marks a byte cycle
    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
            saAddress <= '0;
        else if (writeStart && sel == selSa)
        begin
            if (!qbusIn.wtbt || !addr0)
                saAddress[7:0] <= qbusIn.dal[7:0];
            if (!qbusIn.wtbt || addr0)
                saAddress[`DATA_W-1:8] <= qbusIn.dal[`DATA_W-1:8];
        end
    end

    ////////////////////
    // Events and bus outputs
    ////////////////////

    always_comb
    begin
        qEvent.ipRead    = readStart && sel == selIp;
        qEvent.ipWritten = writeStart && sel == selIp;
        qEvent.saRead    = readStart && sel == selSa;
        qEvent.saWritten = writeStart && sel == selSa;
    end

    assign ipWriteClear = writeStart && sel == selIp;   // Resets SA status on host side

    // IP reads back as zero
    assign qbusOut.dalOe = state == qReadData;
    assign qbusOut.reply = state == qReadData || state == qWriteData;
    assign qbusOut.dal   = (state == qReadData && sel == selSa) ? saStatus : '0;

endmodule

//--- rtl/hostPort/hostRegisters.sv
`timescale 1ns/1ps
`include "qBridge_config.svh"

module hostRegisters
    import qBridgePkg::*;
(
    input  logic                BRPLYf,             // System clock
    input  logic                F_IP_read_enable,   // Async reset, active high
    input  hostBusT             host,               // Host bus inputs
    input  logic [`DATA_W-1:0]  saAddress,          // Written by the PDP-11
    input  statusFlagsT         flagSnapshot,       // Flags frozen at address latch
    input  logic                ipWriteClear,       // PDP-11 wrote IP
    output hostReadT            hostRead,
    output logic [`DATA_W-1:0]  saStatus,           // Read by the PDP-11
    output logic                irReadClear         // First cycle of an IR read
);

    // Register map slices for word compare
    localparam logic [`HOST_ADDR_W-1:0] irHostAddress = `FADDR_IR;
    localparam logic [`HOST_ADDR_W-1:0] saHostAddress = `FADDR_SA;

    logic [`HOST_ADDR_W-1:0]    hostAddr;           // Latched address
    hostRegE                    hostReg;            // Decoded target
    logic                       readActive;
    logic                       writeActive;
    logic                       irRead;             // IR read in progress
    logic                       irReadD;            // Previous cycle of the above

    assign readActive  = host.chipSel && host.readEn;
    assign writeActive = host.chipSel && host.writeEn;

    ////////////////////
    // Address phase
    ////////////////////

    // Captured at the edge, used for decode from the next cycle
    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
            hostAddr <= '0;
        else if (host.addrLatch)
            hostAddr <= host.addr;
    end

    // Word granularity, byte bit ignored
    always_comb
    begin
        if (hostAddr[`HOST_ADDR_W-1:1] == irHostAddress[`HOST_ADDR_W-1:1])
            hostReg = regIr;
        else if (hostAddr[`HOST_ADDR_W-1:1] == saHostAddress[`HOST_ADDR_W-1:1])
            hostReg = regSa;
        else
            hostReg = regNone;
    end

    ////////////////////
    // SA status register
    ////////////////////

    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
            saStatus <= '0;
        else if (ipWriteClear)                          // Controller init from the PDP-11
            saStatus <= '0;
        else if (writeActive && hostReg == regSa)
        begin
            if (host.byteEn[0])
                saStatus[7:0] <= host.data[7:0];        // Low byte
            if (host.byteEn[1])
                saStatus[`DATA_W-1:8] <= host.data[`DATA_W-1:8];  // High byte
        end
    end

    ////////////////////
    // Read path
    ////////////////////

    // Straight from stored state, no read latency
    always_comb
    begin
        hostRead.oe   = readActive;
        hostRead.data = '0;
        if (readActive)
        begin
            case (hostReg)
                regIr:   hostRead.data = {{(`DATA_W-$bits(statusFlagsT)){1'b0}}, flagSnapshot};
                regSa:   hostRead.data = saAddress;
                default: hostRead.data = '0;            // Unmapped reads as zero
            endcase
        end
    end

    // Clear pulse only on the leading cycle of an IR read
    assign irRead = readActive && hostReg == regIr;

    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
            irReadD <= 1'b0;
        else
            irReadD <= irRead;
    end

    assign irReadClear = irRead && !irReadD;

endmodule

//--- common/qBridgePkg.sv
package qBridgePkg;

    `include "qBridge_config.svh"

    //////////////////////
    // Bus bundles
    //////////////////////

    // Host external memory bus, already logical active-high levels
    typedef struct packed {
        logic                       addrLatch;  // Address phase strobe
        logic                       chipSel;    // Bridge selected
        logic                       readEn;     // Read strobe
        logic                       writeEn;    // Write strobe
        logic [1:0]                 byteEn;     // Bit 0 low byte, bit 1 high byte
        logic [`HOST_ADDR_W-1:0]    addr;       // Byte address
        logic [`DATA_W-1:0]         data;       // Write data
    } hostBusT;

    // Host read return, board handles the tristate
    typedef struct packed {
        logic [`DATA_W-1:0]         data;
        logic                       oe;         // Drive enable
    } hostReadT;

    // Qbus inputs as seen by the slave, polarity already removed
    typedef struct packed {
        logic                       sync;
        logic                       din;
        logic                       dout;
        logic                       wtbt;       // High on write means byte cycle
        logic                       bs7;        // I/O page select
        logic                       init;       // Bus init, aborts a cycle
        logic [`QADDR_W-1:0]        dal;        // Address / data lines
    } qbusInT;

    typedef struct packed {
        logic [`DATA_W-1:0]         dal;        // Read data toward the PDP-11
        logic                       dalOe;      // DAL driver enable
        logic                       reply;      // Slave reply level
    } qbusOutT;

    // Event flags, ipRead lands in bit 0 of the IR word
    typedef struct packed {
        logic                       saWritten;
        logic                       saRead;
        logic                       ipWritten;
        logic                       ipRead;
    } statusFlagsT;

    //////////////////////
    // Decode and FSM types
    //////////////////////

    typedef enum logic [1:0] {
        regIr,
        regSa,
        regNone
    } hostRegE;

    typedef enum logic [1:0] {
        qIdle,                                  // Waiting for sync
        qAddressed,                             // Selected, waiting for din or dout
        qReadData,                              // Driving DAL and reply
        qWriteData                              // Data taken, replying
    } qSlaveStateE;

    typedef enum logic [1:0] {
        selNone,
        selIp,
        selSa
    } qSelE;

endpackage

//--- common/qBridge_config.svh
`ifndef QBRIDGE_CONFIG_SVH
`define QBRIDGE_CONFIG_SVH

//////////////////////
// Word and bus widths
//////////////////////

`define DATA_W          16              // Data word on both buses
`define QADDR_W         22              // Full Qbus address
`define HOST_ADDR_W     8               // Host byte address

//////////////////////
// Host side register map
//////////////////////

// Byte addresses, decoded on word boundaries
`define FADDR_IR        8'h00           // Event flags, read and clear
`define FADDR_SA        8'h02           // SA status write / SA address read

//////////////////////
// Qbus side register map
//////////////////////

`define QADDR_IP        22'o17772150    // IP register, I/O page
`define QADDR_SA        22'o17772152    // SA register, I/O page

// Only this slice of the Qbus address is compared
// BS7 already qualifies the I/O page
`define QDEC_LSB        1
`define QDEC_MSB        12

`endif
